// File: testbench/arb_input.txt
# Columns: command, arg a, arg b (hex)
# pulse a=mask b=merged, enable a=level b=cycles, reset b=cycles, expect_merge a=value
enable 1 4
pulse 01 00
drain 0 0
pulse a5 00
drain 0 0
rand 0 0
drain 0 0
rand 0 0
drain 0 0
enable 0 4
pulse ff 00
enable 0 28
expect_merge 0 0
enable 1 4
drain 0 0
enable 0 2
pulse 04 00
enable 0 4
pulse 04 00
enable 0 4
pulse 04 00
enable 0 4
pulse 04 04
enable 0 4
expect_merge 1 0
enable 1 2
drain 0 0
enable 0 2
pulse 81 00
enable 0 4
reset 0 4
expect_merge 0 0
enable 1 14
pulse 3c 00
drain 0 0

// File: project.f
src/arb_pkg.sv
src/tree_node.sv
src/tag_tree.sv
src/req_capture.sv
src/grant_issue.sv
src/snoop_arb_top.sv
testbench/tb_snoop_arb.sv

// File: Bender.yml
package:
  name: snoop_arb

sources:
  - src/arb_pkg.sv
  - src/tree_node.sv
  - src/tag_tree.sv
  - src/req_capture.sv
  - src/grant_issue.sv
  - src/snoop_arb_top.sv
  - target: test
    files:
      - testbench/tb_snoop_arb.sv

// File: testbench/tb_snoop_arb.sv
module tb_snoop_arb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_SRC      = 8;
   localparam int SRC_W        = $clog2(NUM_SRC);
   localparam int MAX_CMDS     = 64;
   localparam int DRAIN_CYCLES = 64;

   logic               clk_i = 1'b0;
   logic               rst_n_i;
   logic [NUM_SRC-1:0] req_i;
   logic               grant_en_i;
   arb_pkg::grant_t    grant_o;
   logic               merge_o;

   // Command table loaded from the input file
   logic [8*16-1:0] cmds [MAX_CMDS];
   logic [31:0]     arg_a [MAX_CMDS];
   logic [31:0]     arg_b [MAX_CMDS];
   int              num_cmds = 0;

   // Expected and observed grants per source
   int              exp_cnt [NUM_SRC];
   int              got_cnt [NUM_SRC];
   int              cycle_cnt = 0;
   int              cycle_limit = 0;
   integer          seed;
   logic [SRC_W-1:0] grant_src;

   snoop_arb_top #(
      .NUM_SRC   (NUM_SRC),
      .DELAY_CONF(arb_pkg::DELAY_ALTERNATE)
   ) u_dut (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .req_i     (req_i),
      .grant_en_i(grant_en_i),
      .grant_o   (grant_o),
      .merge_o   (merge_o)
   );

   always #4 clk_i = ~clk_i;

   task automatic stop_on_error();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
         stop_on_error();
      end
   endtask

   // Inputs change 1 ns after the rising edge
   task automatic step();
      @(posedge clk_i);
      #1;
   endtask

   task automatic clear_model();
      for (int s = 0; s < NUM_SRC; s++) begin
         exp_cnt[s] = 0;
         got_cnt[s] = 0;
      end
   endtask

   function automatic int total(input bit use_got);
      int sum;
      sum = 0;
      for (int s = 0; s < NUM_SRC; s++) begin
         sum += use_got ? got_cnt[s] : exp_cnt[s];
      end
      return sum;
   endfunction

   // Absorbed bits name pulses that fold into a request already waiting
   task automatic send_pulse(input logic [NUM_SRC-1:0] mask,
                             input logic [NUM_SRC-1:0] absorbed);
      req_i = mask;
      for (int s = 0; s < NUM_SRC; s++) begin
         if (mask[s] && !absorbed[s]) begin
            exp_cnt[s]++;
         end
      end
      step();
      req_i = '0;
   endtask

   task automatic run_enable(input logic level, input int cycles);
      grant_en_i = level;
      repeat (cycles) begin
         step();
         if (!level) begin
            check_value("grant_o.valid", grant_o.valid, 32'h0);
         end
      end
   endtask

   // Missing grants show up as a count mismatch once the allowance runs out
   task automatic drain_grants();
      int waited;
      waited = 0;
      while (total(1'b1) != total(1'b0) && waited < DRAIN_CYCLES) begin
         step();
         waited++;
      end
      for (int s = 0; s < NUM_SRC; s++) begin
         check_value($sformatf("grant count of source %0d", s), got_cnt[s], exp_cnt[s]);
      end
   endtask

   task automatic apply_reset(input int cycles);
      rst_n_i = 1'b0;
      clear_model();
      repeat (cycles) begin
         step();
      end
      rst_n_i = 1'b1;
   endtask

   task automatic load_commands();
      integer          fd;
      integer          n;
      logic [8*96-1:0] line_buf;
      logic [8*16-1:0] word;
      logic [31:0]     a;
      logic [31:0]     b;
      fd = $fopen("testbench/arb_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open testbench/arb_input.txt");
         stop_on_error();
      end
      while (!$feof(fd) && num_cmds < MAX_CMDS) begin
         line_buf = '0;
         word = '0;
         n = $fgets(line_buf, fd);
         n = $sscanf(line_buf, "%s %h %h", word, a, b);
         if (n == 3 && word != "#") begin
            cmds[num_cmds]  = word;
            arg_a[num_cmds] = a;
            arg_b[num_cmds] = b;
            // Run budget, drains get a fixed allowance
            if (word == "drain") begin
               cycle_limit += DRAIN_CYCLES;
            end else if (word == "enable" || word == "reset") begin
               cycle_limit += b;
            end else begin
               cycle_limit += 1;
            end
            num_cmds++;
         end
      end
      $fclose(fd);
      cycle_limit += 16;
   endtask

   // Grants are counted mid-cycle where the registered output is stable
   always @(negedge clk_i) begin
      if (rst_n_i === 1'b1 && grant_o.valid === 1'b1) begin
         grant_src = grant_o.tag[SRC_W-1:0];
         if (grant_o.tag >= NUM_SRC) begin
            $display("Grant tag 0x%0h does not name any source", grant_o.tag);
            stop_on_error();
         end else if (got_cnt[grant_src] >= exp_cnt[grant_src]) begin
            $display("Grant for source %0d arrived without a request from it",
                     grant_src);
            stop_on_error();
         end else begin
            got_cnt[grant_src]++;
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
         $display("Run did not finish within %0d cycles", cycle_limit);
         stop_on_error();
      end
   end

   initial begin
      logic [31:0] rnd;
      rst_n_i    = 1'b0;
      req_i      = '0;
      grant_en_i = 1'b0;
      seed       = 32'hd88cd32f;
      clear_model();
      load_commands();
      apply_reset(4);
      for (int i = 0; i < num_cmds; i++) begin
         if (cmds[i] == "pulse") begin
            send_pulse(arg_a[i][NUM_SRC-1:0], arg_b[i][NUM_SRC-1:0]);
         end else if (cmds[i] == "rand") begin
            rnd = $random(seed);
            send_pulse(rnd[NUM_SRC-1:0], '0);
         end else if (cmds[i] == "enable") begin
            run_enable(arg_a[i][0], arg_b[i]);
         end else if (cmds[i] == "drain") begin
            drain_grants();
         end else if (cmds[i] == "expect_merge") begin
            check_value("merge_o", merge_o, arg_a[i]);
         end else if (cmds[i] == "reset") begin
            apply_reset(arg_b[i]);
         end else begin
            $display("Unknown command %0d in the input file", i);
            stop_on_error();
         end
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule

// File: src/snoop_arb_top.sv
// Snooping cache request arbiter, capture then tag tree then grant stage
module snoop_arb_top #(
   parameter int         NUM_SRC    = 8,
   parameter logic [1:0] DELAY_CONF = arb_pkg::DELAY_ALTERNATE
) (
   input  logic               clk_i,
   input  logic               rst_n_i,

   input  logic [NUM_SRC-1:0] req_i,
   input  logic               grant_en_i,

   output arb_pkg::grant_t    grant_o,
   output logic               merge_o
);

   localparam int TAG_W = $clog2(NUM_SRC);

   logic [NUM_SRC-1:0] pending;
   logic [NUM_SRC-1:0] src_ack;
   arb_pkg::node_out_t root;
   logic               root_ack;

   req_capture #(
      .NUM_SRC(NUM_SRC)
   ) u_capture (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (req_i),
      .src_ack_i(src_ack),
      .pending_o(pending),
      .merge_o  (merge_o)
   );

   tag_tree #(
      .NUM_SRC   (NUM_SRC),
      .DELAY_CONF(DELAY_CONF),
      .TAG_W     (TAG_W)
   ) u_tree (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .pending_i (pending),
      .src_ack_o (src_ack),
      .root_o    (root),
      .root_ack_i(root_ack)
   );

   grant_issue #(
      .TAG_W(TAG_W)
   ) u_issue (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .root_i    (root),
      .grant_en_i(grant_en_i),
      .root_ack_o(root_ack),
      .grant_o   (grant_o)
   );

endmodule

// File: src/grant_issue.sv
// Output stage, takes one tag per cycle from the root while enabled
module grant_issue #(
   parameter int TAG_W = 3
) (
   input  logic               clk_i,
   input  logic               rst_n_i,

   input  arb_pkg::node_out_t root_i,
   input  logic               grant_en_i,
   output logic               root_ack_o,

   output arb_pkg::grant_t    grant_o
);

   logic             valid_q;
   logic [TAG_W-1:0] tag_q;

   // Consumer enable gates the ack, so back-pressure stalls the tree
   assign root_ack_o = root_i.rdy & grant_en_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= root_ack_o;
      end
   end

   always_ff @(posedge clk_i) begin
      if (root_ack_o) begin
         tag_q <= root_i.tag[TAG_W-1:0];
      end
   end

   assign grant_o = arb_pkg::grant_t'{
      valid: valid_q,
      tag:   arb_pkg::tag_t'(tag_q)
   };

   a_no_grant_when_off : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !grant_en_i |=> !grant_o.valid)
      else $error("grant_issue: grant issued while consumer disabled");

endmodule

// File: src/req_capture.sv
// Holds request pulses as pending levels until the tree serves them
module req_capture #(
   parameter int NUM_SRC = 8
) (
   input  logic               clk_i,
   input  logic               rst_n_i,

   input  logic [NUM_SRC-1:0] req_i,
   input  logic [NUM_SRC-1:0] src_ack_i,

   output logic [NUM_SRC-1:0] pending_o,
   output logic               merge_o
);

   logic [NUM_SRC-1:0] pending_q;
   logic               merge_q;
   logic [NUM_SRC-1:0] merged;

   // A pulse on a bit that stays set folds into the existing request
   assign merged = req_i & pending_q & ~src_ack_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pending_q <= '0;
         merge_q   <= 1'b0;
      end else begin
         // Ack clears, a new pulse in the same cycle sets again
         pending_q <= (pending_q & ~src_ack_i) | req_i;
         if (|merged) begin
            merge_q <= 1'b1;
         end
      end
   end

   assign pending_o = pending_q;
   assign merge_o   = merge_q;

   a_ack_pending : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (src_ack_i & ~pending_q) == '0)
      else $error("req_capture: leaf ack without pending request");

endmodule

// File: src/tag_tree.sv
// Binary tree of arbitration nodes reducing pending requests to one tag
module tag_tree #(
   parameter int         NUM_SRC    = 8,
   parameter logic [1:0] DELAY_CONF = arb_pkg::DELAY_ALTERNATE,
   parameter int         TAG_W      = 3
) (
   input  logic               clk_i,
   input  logic               rst_n_i,

   input  logic [NUM_SRC-1:0] pending_i,
   output logic [NUM_SRC-1:0] src_ack_o,

   output arb_pkg::node_out_t root_o,
   input  logic               root_ack_i
);

   localparam int NUM_NODES = 2*NUM_SRC - 1;

   // Leaves sit at 0..NUM_SRC-1, node k drives entry k+NUM_SRC, root is last
   arb_pkg::node_out_t         nodes [NUM_NODES];
   logic [NUM_NODES-1:0]       acks;

   for (genvar k = 0; k < NUM_SRC; k++) begin : g_leaf
      localparam logic [TAG_W-1:0] LEAF_TAG = k;

      assign nodes[k] = arb_pkg::node_out_t'{
         rdy: pending_i[k],
         tag: arb_pkg::tag_t'(LEAF_TAG)
      };
      assign src_ack_o[k] = acks[k];
   end

   for (genvar k = 0; k < NUM_SRC-1; k++) begin : g_node
      // Level of the node counted from the root, root is level 1
      localparam int  LEVEL = $clog2(NUM_SRC - k);
      localparam bit  DELAY = (DELAY_CONF == arb_pkg::DELAY_ALL) ||
                              ((DELAY_CONF == arb_pkg::DELAY_ALTERNATE) &&
                               (LEVEL % 2 == 1));

      tree_node #(
         .ENABLE_DELAY(DELAY)
      ) u_node (
         .clk_i      (clk_i),
         .rst_n_i    (rst_n_i),
         .left_i     (nodes[2*k]),
         .left_ack_o (acks[2*k]),
         .right_i    (nodes[2*k+1]),
         .right_ack_o(acks[2*k+1]),
         .out_o      (nodes[k+NUM_SRC]),
         .ack_i      (acks[k+NUM_SRC])
      );
   end

   assign root_o              = nodes[NUM_NODES-1];
   assign acks[NUM_NODES-1]   = root_ack_i;

endmodule

// File: src/tree_node.sv
// Two-input round-robin node of the tag tree
module tree_node #(
   parameter bit ENABLE_DELAY = 1'b0
) (
   input  logic              clk_i,
   input  logic              rst_n_i,

   input  arb_pkg::node_out_t left_i,
   output logic              left_ack_o,

   input  arb_pkg::node_out_t right_i,
   output logic              right_ack_o,

   output arb_pkg::node_out_t out_o,
   input  logic              ack_i
);

   logic          last_right_q;
   logic          hold_q;
   logic          hold_left_q;
   logic          pick_left;
   logic          sel_rdy;
   arb_pkg::tag_t sel_tag;
   logic          take;

   // Keep an offered child until it transfers so the tag cannot change under rdy
   assign pick_left = hold_q ? hold_left_q :
                      (left_i.rdy && (!right_i.rdy || last_right_q));
   assign sel_rdy   = left_i.rdy | right_i.rdy;
   assign sel_tag   = pick_left ? left_i.tag : right_i.tag;

   assign left_ack_o  = take & pick_left;
   assign right_ack_o = take & ~pick_left;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         last_right_q <= 1'b0;
         hold_q       <= 1'b0;
      end else begin
         if (take) begin
            last_right_q <= ~pick_left;
         end
         hold_q <= sel_rdy & ~take;
      end
   end

   always_ff @(posedge clk_i) begin
      hold_left_q <= pick_left;
   end

   if (ENABLE_DELAY) begin : g_reg
      logic          vld_q;
      arb_pkg::tag_t tag_q;

      // Load when empty or when the parent drains us this cycle
      assign take = sel_rdy & (~vld_q | ack_i);

      always_ff @(posedge clk_i) begin
         if (!rst_n_i) begin
            vld_q <= 1'b0;
         end else if (take) begin
            vld_q <= 1'b1;
         end else if (ack_i) begin
            vld_q <= 1'b0;
         end
      end

      always_ff @(posedge clk_i) begin
         if (take) begin
            tag_q <= sel_tag;
         end
      end

      assign out_o = arb_pkg::node_out_t'{rdy: vld_q, tag: tag_q};
   end else begin : g_comb
      // Ack passes straight down to the chosen child
      assign take  = ack_i;
      assign out_o = arb_pkg::node_out_t'{rdy: sel_rdy, tag: sel_tag};
   end

   a_one_ack : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(left_ack_o && right_ack_o))
      else $error("tree_node: both children acked");

   a_left_rdy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      left_ack_o |-> left_i.rdy)
      else $error("tree_node: ack to idle left child");

   a_right_rdy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      right_ack_o |-> right_i.rdy)
      else $error("tree_node: ack to idle right child");

endmodule

// File: src/arb_pkg.sv
// Shared types and constants for the snoop request arbiter
package arb_pkg;

   // Widest tag any tree may carry, sets the struct widths
   localparam int MAX_TAG_W = 8;

   // Delay configurations for the tag tree
   localparam logic [1:0] DELAY_NONE      = 2'd0;
   localparam logic [1:0] DELAY_ALTERNATE = 2'd1;
   localparam logic [1:0] DELAY_ALL       = 2'd2;

   typedef logic [MAX_TAG_W-1:0] tag_t;

   // What a node shows its parent
   // rdy is held until ack, tag stays stable while rdy is high
   typedef struct packed {
      logic rdy;
      tag_t tag;
   } node_out_t;

   // Grant leaving the arbiter, valid for one cycle per grant
   typedef struct packed {
      logic valid;
      tag_t tag;
   } grant_t;

endpackage
